/* src/backendPkg.sv */
package backendPkg;

    ////////////////////
    // Sizes
    ////////////////////

    localparam int IdWidth     = 8;
    localparam int NumTags     = 6;
    localparam int RobDepth    = 8;
    localparam int RobIdxWidth = 3;
    localparam int IqDepth     = 4;

    // Derived widths.
    localparam int TagWidth    = $clog2(NumTags);
    localparam int TagCntWidth = $clog2(NumTags + 1);
    localparam int RobCntWidth = $clog2(RobDepth + 1);
    localparam int IqPtrWidth  = $clog2(IqDepth);
    localparam int IqCntWidth  = $clog2(IqDepth + 1);

    ////////////////////
    // Types
    ////////////////////

    typedef enum logic [1:0] {
        UnitAlu = 2'd0,
        UnitLsu = 2'd1,
        UnitMdu = 2'd2
    } unitClassE;

    // One instruction as it moves through the front stages.
    typedef struct packed {
        logic               valid;
        logic [IdWidth-1:0] id;
        unitClassE          unitClass;
        logic               mark;
    } instT;

endpackage

/* src/ctrlIf.sv */
`timescale 1ns/1ns

interface Ctrl;

    // Set by the controller.
    logic pause;
    logic flush;

    // Set by the stage that owns this link.
    logic pauseReq;
    logic flushReq;

    modport master (
        output pause,
        output flush,
        input  pauseReq,
        input  flushReq
    );

    modport slave (
        input  pause,
        input  flush,
        output pauseReq,
        output flushReq
    );

endinterface

/* src/ctrlUnitBackend.sv */
`timescale 1ns/1ns

module ctrlUnitBackend (
    Ctrl.master  ctrlBufDecode,
    Ctrl.master  ctrlDecodeRename,
    Ctrl.master  ctrlRob,
    Ctrl.master  ctrlCommit,

    input  logic aluIqReady,
    input  logic lsuIqReady,
    input  logic mduIqReady,
    input  logic renameAllocatable,

    output logic pauseRename,
    output logic renameRecover,
    output logic aluIqFlush,
    output logic lsuIqFlush,
    output logic mduIqFlush,
    output logic flushOut
);

    logic dispatchBlocked;

    // Anything downstream of rename that cannot take one more entry.
    assign dispatchBlocked = ctrlRob.pauseReq || !aluIqReady || !lsuIqReady || !mduIqReady;

    ////////////////////
    // Pause
    ////////////////////

    assign ctrlBufDecode.pause    = dispatchBlocked || !renameAllocatable;
    assign ctrlDecodeRename.pause = dispatchBlocked || !renameAllocatable;
    assign pauseRename            = dispatchBlocked;
    assign ctrlRob.pause          = dispatchBlocked;
    assign ctrlCommit.pause       = 1'b0;   // retirement never waits

    ////////////////////
    // Flush
    ////////////////////

    assign ctrlBufDecode.flush    = ctrlCommit.flushReq;
    assign ctrlDecodeRename.flush = ctrlCommit.flushReq;
    assign ctrlRob.flush          = ctrlCommit.flushReq;
    assign ctrlCommit.flush       = ctrlCommit.flushReq;
    assign renameRecover          = ctrlCommit.flushReq;
    assign aluIqFlush             = ctrlCommit.flushReq;
    assign lsuIqFlush             = ctrlCommit.flushReq;
    assign mduIqFlush             = ctrlCommit.flushReq;
    assign flushOut               = ctrlCommit.flushReq;

endmodule

/* src/pipeReg.sv */
`timescale 1ns/1ns

module pipeReg
    import backendPkg::*;
(
    input  logic clk,
    input  logic arstN,
    Ctrl.slave   ctrl,
    input  instT din,
    output instT dout
);

    logic               validQ;
    logic [IdWidth-1:0] idQ;
    unitClassE          classQ;
    logic               markQ;

    // Flush wins over pause.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= 1'b0;
        end else if (ctrl.flush) begin
            validQ <= 1'b0;
        end else if (!ctrl.pause) begin
            validQ <= din.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!ctrl.pause) begin
            idQ    <= din.id;
            classQ <= din.unitClass;
            markQ  <= din.mark;
        end
    end

    assign dout = '{valid: validQ, id: idQ, unitClass: classQ, mark: markQ};

    assign ctrl.pauseReq = 1'b0;
    assign ctrl.flushReq = 1'b0;

endmodule

/* src/renameAlloc.sv */
`timescale 1ns/1ns

module renameAlloc
    import backendPkg::*;
(
    input  logic                clk,
    input  logic                arstN,
    input  logic                allocate,
    input  logic                tagRelease,
    input  logic                recover,
    output logic                allocatable,
    output logic [TagWidth-1:0] tag
);

    logic [TagCntWidth-1:0] freeCount;
    logic [TagWidth-1:0]    nextTag;

    ////////////////////
    // Free count
    ////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            freeCount <= TagCntWidth'(NumTags);
        end else if (recover) begin
            freeCount <= TagCntWidth'(NumTags);
        end else begin
            case ({allocate, tagRelease})
                2'b10:   freeCount <= freeCount - 1'b1;
                2'b01:   freeCount <= freeCount + 1'b1;
                default: freeCount <= freeCount;
            endcase
        end
    end

    ////////////////////
    // Tag pointer
    ////////////////////

    // Tags hand out round robin.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            nextTag <= '0;
        end else if (recover) begin
            nextTag <= '0;
        end else if (allocate) begin
            if (nextTag == TagWidth'(NumTags - 1)) begin
                nextTag <= '0;
            end else begin
                nextTag <= nextTag + 1'b1;
            end
        end
    end

    assign allocatable = (freeCount != '0);
    assign tag         = nextTag;

endmodule

/* src/issueQueue.sv */
`timescale 1ns/1ns

module issueQueue
    import backendPkg::*;
(
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   push,
    input  logic                   flush,
    input  logic                   execReady,
    input  logic [RobIdxWidth-1:0] pushIdx,
    output logic                   ready,
    output logic                   issueValid,
    output logic [RobIdxWidth-1:0] issueIdx
);

    logic [RobIdxWidth-1:0] entries [IqDepth];
    logic [IqPtrWidth-1:0]  headPtr;
    logic [IqPtrWidth-1:0]  tailPtr;
    logic [IqCntWidth-1:0]  count;
    logic                   doPush;
    logic                   doPop;

    assign ready  = (count != IqCntWidth'(IqDepth));
    assign doPush = push && ready;
    assign doPop  = execReady && (count != '0);

    ////////////////////
    // Pointers
    ////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count   <= '0;
        end else if (flush) begin
            headPtr <= '0;
            tailPtr <= '0;
            count   <= '0;
        end else begin
            if (doPush) begin
                tailPtr <= tailPtr + 1'b1;
            end
            if (doPop) begin
                headPtr <= headPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage.
    always_ff @(posedge clk) begin
        if (doPush) begin
            entries[tailPtr] <= pushIdx;
        end
    end

    // Head leaves in the same cycle it is shown.
    assign issueValid = doPop;
    assign issueIdx   = entries[headPtr];

endmodule

/* src/reorderBuffer.sv */
`timescale 1ns/1ns

module reorderBuffer
    import backendPkg::*;
(
    input  logic                   clk,
    input  logic                   arstN,
    Ctrl.slave                     ctrlRob,
    Ctrl.slave                     ctrlCommit,
    input  logic                   dispatch,
    input  instT                   dispatchInst,
    output logic [RobIdxWidth-1:0] allocIdx,
    input  logic                   doneValid0,
    input  logic                   doneValid1,
    input  logic                   doneValid2,
    input  logic [RobIdxWidth-1:0] doneIdx0,
    input  logic [RobIdxWidth-1:0] doneIdx1,
    input  logic [RobIdxWidth-1:0] doneIdx2,
    output logic                   commitValid,
    output logic [IdWidth-1:0]     commitId,
    output unitClassE              commitClass
);

    logic [IdWidth-1:0]     idMem    [RobDepth];
    unitClassE              classMem [RobDepth];
    logic [RobDepth-1:0]    markMem;
    logic [RobDepth-1:0]    doneBits;
    logic [RobIdxWidth-1:0] headPtr;
    logic [RobIdxWidth-1:0] tailPtr;
    logic [RobCntWidth-1:0] count;
    logic                   full;
    logic                   doWrite;
    logic                   flushAll;

    assign full     = (count == RobCntWidth'(RobDepth));
    assign doWrite  = dispatch && !ctrlRob.pause && !full;
    assign flushAll = ctrlRob.flush || ctrlCommit.flush;
    assign allocIdx = tailPtr;

    ////////////////////
    // Pointers and done
    ////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            headPtr  <= '0;
            tailPtr  <= '0;
            count    <= '0;
            doneBits <= '0;
        end else if (flushAll) begin
            headPtr  <= '0;
            tailPtr  <= '0;
            count    <= '0;
            doneBits <= '0;
        end else begin
            if (doWrite) begin
                tailPtr           <= tailPtr + 1'b1;
                doneBits[tailPtr] <= 1'b0;
            end
            // Completion comes one cycle after issue.
            if (doneValid0) doneBits[doneIdx0] <= 1'b1;
            if (doneValid1) doneBits[doneIdx1] <= 1'b1;
            if (doneValid2) doneBits[doneIdx2] <= 1'b1;
            if (commitValid) begin
                headPtr <= headPtr + 1'b1;
            end
            case ({doWrite, commitValid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doWrite) begin
            idMem[tailPtr]    <= dispatchInst.id;
            classMem[tailPtr] <= dispatchInst.unitClass;
            markMem[tailPtr]  <= dispatchInst.mark;
        end
    end

    // In-order retire, one per cycle.
    assign commitValid = (count != '0) && doneBits[headPtr] && !ctrlCommit.pause;
    assign commitId    = idMem[headPtr];
    assign commitClass = classMem[headPtr];

    assign ctrlRob.pauseReq    = full;
    assign ctrlRob.flushReq    = 1'b0;
    assign ctrlCommit.pauseReq = 1'b0;
    assign ctrlCommit.flushReq = commitValid && markMem[headPtr];

endmodule

/* src/backendTop.sv */
`timescale 1ns/1ns

module backendTop
    import backendPkg::*;
(
    input  logic               clk,
    input  logic               arstN,
    input  logic               insValid,
    input  logic [IdWidth-1:0] insId,
    input  logic [1:0]         insClass,
    input  logic               insMark,
    input  logic               aluExecReady,
    input  logic               lsuExecReady,
    input  logic               mduExecReady,
    output logic               stall,
    output logic               commitValid,
    output logic [IdWidth-1:0] commitId,
    output logic [1:0]         commitClass,
    output logic               flushOut
);

    Ctrl ctrlBufDecode ();
    Ctrl ctrlDecodeRename ();
    Ctrl ctrlRob ();
    Ctrl ctrlCommit ();

    instT                   insInst;
    instT                   decodeInst;
    instT                   renameInst;
    logic                   aluIqReady, lsuIqReady, mduIqReady;
    logic                   aluIqFlush, lsuIqFlush, mduIqFlush;
    logic                   renameAllocatable, pauseRename, renameRecover;
    logic                   renameDispatch;
    logic [RobIdxWidth-1:0] allocIdx;
    logic [2:0]             issueValid;
    logic [RobIdxWidth-1:0] issueIdx [3];
    logic [2:0]             doneValidQ;
    logic [RobIdxWidth-1:0] doneIdxQ [3];
    unitClassE              commitClassE;

    assign insInst = '{valid: insValid, id: insId, unitClass: unitClassE'(insClass),
                       mark: insMark};
    assign stall       = ctrlBufDecode.pause;
    assign commitClass = commitClassE;

    ctrlUnitBackend uCtrlUnit (
        .ctrlBufDecode    (ctrlBufDecode.master),
        .ctrlDecodeRename (ctrlDecodeRename.master),
        .ctrlRob          (ctrlRob.master),
        .ctrlCommit       (ctrlCommit.master),
        .aluIqReady, .lsuIqReady, .mduIqReady, .renameAllocatable,
        .pauseRename, .renameRecover, .aluIqFlush, .lsuIqFlush, .mduIqFlush, .flushOut
    );

    ////////////////////
    // Front stages
    ////////////////////

    pipeReg uBufDecodeReg (
        .clk, .arstN, .ctrl(ctrlBufDecode.slave), .din(insInst), .dout(decodeInst)
    );

    pipeReg uDecodeRenameReg (
        .clk, .arstN, .ctrl(ctrlDecodeRename.slave), .din(decodeInst), .dout(renameInst)
    );

    // Needs a free tag too, else the held entry would dispatch twice.
    assign renameDispatch = renameInst.valid && !pauseRename && renameAllocatable;

    renameAlloc uRenameAlloc (
        .clk, .arstN, .allocate(renameDispatch), .tagRelease(commitValid),
        .recover(renameRecover), .allocatable(renameAllocatable), .tag()
    );

    ////////////////////
    // Issue queues
    ////////////////////

    issueQueue uAluIq (
        .clk, .arstN, .flush(aluIqFlush), .execReady(aluExecReady), .pushIdx(allocIdx),
        .push(renameDispatch && renameInst.unitClass != UnitLsu
              && renameInst.unitClass != UnitMdu),
        .ready(aluIqReady), .issueValid(issueValid[0]), .issueIdx(issueIdx[0])
    );

    issueQueue uLsuIq (
        .clk, .arstN, .flush(lsuIqFlush), .execReady(lsuExecReady), .pushIdx(allocIdx),
        .push(renameDispatch && renameInst.unitClass == UnitLsu),
        .ready(lsuIqReady), .issueValid(issueValid[1]), .issueIdx(issueIdx[1])
    );

    issueQueue uMduIq (
        .clk, .arstN, .flush(mduIqFlush), .execReady(mduExecReady), .pushIdx(allocIdx),
        .push(renameDispatch && renameInst.unitClass == UnitMdu),
        .ready(mduIqReady), .issueValid(issueValid[2]), .issueIdx(issueIdx[2])
    );

    // One-cycle execute.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            doneValidQ <= '0;
        end else if (flushOut) begin
            doneValidQ <= '0;
        end else begin
            doneValidQ <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        doneIdxQ <= issueIdx;
    end

    reorderBuffer uRob (
        .clk, .arstN, .ctrlRob(ctrlRob.slave), .ctrlCommit(ctrlCommit.slave),
        .dispatch(renameDispatch), .dispatchInst(renameInst), .allocIdx,
        .doneValid0(doneValidQ[0]), .doneValid1(doneValidQ[1]), .doneValid2(doneValidQ[2]),
        .doneIdx0(doneIdxQ[0]), .doneIdx1(doneIdxQ[1]), .doneIdx2(doneIdxQ[2]),
        .commitValid, .commitId, .commitClass(commitClassE)
    );

endmodule

/* sim/backendTop_checker.sv */
`timescale 1ns/1ns

module backendTopChecker (
    input logic clk,
    input logic arstN,
    input logic commitValid,
    input logic flushOut
);

    // Only a retiring marked entry flushes.
    flushNeedsCommit: assert property (@(posedge clk) disable iff (!arstN)
        flushOut |-> commitValid)
        else $error("flushOut high without commitValid");

    noCommitInReset: assert property (@(posedge clk)
        !arstN |-> !commitValid)
        else $error("commitValid high while reset is asserted");

    // Pipeline is empty after a flush and refills over several cycles.
    quietAfterFlush: assert property (@(posedge clk) disable iff (!arstN)
        flushOut |=> !commitValid [*3])
        else $error("commit within 3 cycles of a flush");

endmodule

bind backendTop backendTopChecker uChecker (
    .clk         (clk),
    .arstN       (arstN),
    .commitValid (commitValid),
    .flushOut    (flushOut)
);

/* sim/backendTb.sv */
`timescale 1ns/1ns

module backendTb
    import backendPkg::*;
();

    localparam int ClkPeriod = 4;
    localparam int MaxLines  = 32;
    localparam int LineWords = 5;

    logic               clk;
    logic               arstN;
    logic               insValid;
    logic [IdWidth-1:0] insId;
    logic [1:0]         insClass;
    logic               insMark;
    logic               aluExecReady;
    logic               lsuExecReady;
    logic               mduExecReady;
    logic               stall;
    logic               commitValid;
    logic [IdWidth-1:0] commitId;
    logic [1:0]         commitClass;
    logic               flushOut;

    logic [7:0]         stimMem [MaxLines*LineWords];
    int                 numLines;
    int                 limitCycles;
    bit                 stimLoaded;
    int                 checkCount;
    int                 errorCount;

    // Reference model, oldest accepted instruction first.
    logic [IdWidth-1:0] expIds     [$];
    logic [1:0]         expClasses [$];
    logic               expMarks   [$];

    backendTop u_backendTop (
        .clk, .arstN, .insValid, .insId, .insClass, .insMark,
        .aluExecReady, .lsuExecReady, .mduExecReady,
        .stall, .commitValid, .commitId, .commitClass, .flushOut
    );

    initial clk = 1'b0;
    always #(ClkPeriod/2) clk = ~clk;

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("** Error [%s] at %0t: expected %0h, actual %0h",
                     testName, $time, expected, actual);
        end
    endtask

    ////////////////////
    // Commit monitor
    ////////////////////

    always @(posedge clk) begin
        if (arstN) begin
            if (commitValid) begin
                if (expIds.size() == 0) begin
                    errorCount++;
                    $display("Commit of id %0h at %0t with no instruction in flight",
                             commitId, $time);
                end else begin
                    checkValue("commitId", expIds[0], commitId);
                    checkValue("commitClass", expClasses[0], commitClass);
                    checkValue("flushOnMark", expMarks[0], flushOut);
                    void'(expIds.pop_front());
                    void'(expClasses.pop_front());
                    void'(expMarks.pop_front());
                end
            end else if (flushOut) begin
                errorCount++;
                $display("flushOut was high at %0t without a commit", $time);
            end
            if (insValid && !stall) begin
                expIds.push_back(insId);
                expClasses.push_back(insClass);
                expMarks.push_back(insMark);
            end
            // Drops everything younger including the one taken at this edge.
            if (flushOut) begin
                expIds.delete();
                expClasses.delete();
                expMarks.delete();
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic runLine(input int n);
        logic [7:0] gap;
        logic [2:0] mask;
        int         idle;
        gap  = stimMem[LineWords*n+3];
        mask = stimMem[LineWords*n+4][2:0];
        idle = gap + ($urandom % 2);
        @(negedge clk);
        insValid     = 1'b1;
        insId        = stimMem[LineWords*n];
        insClass     = stimMem[LineWords*n+1][1:0];
        insMark      = stimMem[LineWords*n+2][0];
        aluExecReady = mask[0];
        lsuExecReady = mask[1];
        mduExecReady = mask[2];
        // Held on the inputs until taken.
        do begin
            @(posedge clk);
        end while (stall);
        for (int k = 0; k < idle; k++) begin
            @(negedge clk);
            insValid = 1'b0;
        end
        // Full queue or empty tag pool.
        if (mask == 3'b000 && gap >= 6) begin
            checkValue("backpressure", 1, stall);
        end
    endtask

    initial begin
        void'($urandom(32'h8d0ffbbf));
        arstN        = 1'b0;
        insValid     = 1'b0;
        insId        = '0;
        insClass     = '0;
        insMark      = 1'b0;
        aluExecReady = 1'b0;
        lsuExecReady = 1'b0;
        mduExecReady = 1'b0;
        checkCount   = 0;
        errorCount   = 0;
        stimLoaded   = 1'b0;
        // Unread class bytes keep a fill above any class code.
        for (int i = 0; i < MaxLines*LineWords; i++) begin
            stimMem[i] = ~8'(i);
        end
        $readmemh("sim/backendStim.txt", stimMem);
        numLines    = 0;
        limitCycles = 8;
        while (numLines < MaxLines && stimMem[LineWords*numLines+1] <= 8'd2) begin
            limitCycles += stimMem[LineWords*numLines+3] + 40;
            numLines++;
        end
        stimLoaded = 1'b1;
        if (numLines == 0) begin
            errorCount++;
            $display("No stimulus lines were read from sim/backendStim.txt");
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);
        checkValue("resetStall", 0, stall);
        checkValue("resetCommit", 0, commitValid);
        checkValue("resetFlush", 0, flushOut);

        for (int n = 0; n < numLines; n++) begin
            runLine(n);
        end

        @(negedge clk);
        insValid     = 1'b0;
        aluExecReady = 1'b1;
        lsuExecReady = 1'b1;
        mduExecReady = 1'b1;
        while (expIds.size() != 0) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);

        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    ////////////////////
    // Watchdog
    ////////////////////

    initial begin
        wait (stimLoaded);
        #(limitCycles * ClkPeriod);
        $display("Watchdog expired after %0d cycles, the pipeline did not drain", limitCycles);
        $display("tests failed");
        $finish;
    end

endmodule

/* sim/backendStim.txt */
// id class mark gap mask, all hex; class 0 alu, 1 lsu, 2 mdu; mark 1 flushes at commit
// mask bit 0 alu, bit 1 lsu, bit 2 mdu execute ready; gap is idle cycles after acceptance
01 0 0 0 7
02 1 0 0 7
03 2 0 0 7
04 0 0 10 7
10 0 0 0 0
11 0 0 0 0
12 0 0 0 0
13 0 0 8 0
14 0 0 10 7
20 0 0 0 0
21 1 0 0 0
22 2 0 0 0
23 0 0 0 0
24 1 0 0 0
25 2 0 8 0
26 0 0 10 7
30 1 0 0 7
31 2 1 0 7
32 1 0 0 7
33 0 0 c 7
34 1 0 8 7

/* backendTop.f */
src/backendPkg.sv
src/ctrlIf.sv
src/ctrlUnitBackend.sv
src/pipeReg.sv
src/renameAlloc.sv
src/issueQueue.sv
src/reorderBuffer.sv
src/backendTop.sv
sim/backendTop_checker.sv
sim/backendTb.sv

/* Bender.yml */
package:
  name: backend

sources:
  - files:
      - src/backendPkg.sv
      - src/ctrlIf.sv
      - src/ctrlUnitBackend.sv
      - src/pipeReg.sv
      - src/renameAlloc.sv
      - src/issueQueue.sv
      - src/reorderBuffer.sv
      - src/backendTop.sv
  - target: simulation
    files:
      - sim/backendTop_checker.sv
      - sim/backendTb.sv
